//--- Makefile
# Verilator flow for the execute stage
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= executor_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
SIM_EXE   ?= executor_sim
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_EXE): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_EXE)

sim: $(BUILD_DIR)/$(SIM_EXE)
	./$(BUILD_DIR)/$(SIM_EXE) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/cond_check.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Evaluates an ARM condition code against the stored N/Z/C/V flags.
// Combinational; passes gates every effect of the instruction.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "exec_defs.svh"

module cond_check
    import exec_pkg::*;
(
    input  flags_t flags,
    input  cond_t  cond,
    output logic   passes
);

    logic n, z, c, v;

    assign n = flags[`EXEC_FLAG_N];
    assign z = flags[`EXEC_FLAG_Z];
    assign c = flags[`EXEC_FLAG_C];
    assign v = flags[`EXEC_FLAG_V];

    always_comb begin
        case (cond)
            COND_EQ: passes = z;
            COND_NE: passes = !z;
            COND_CS: passes = c;             // Unsigned higher or same
            COND_CC: passes = !c;
            COND_MI: passes = n;
            COND_PL: passes = !n;
            COND_VS: passes = v;
            COND_VC: passes = !v;
            COND_HI: passes = c && !z;
            COND_LS: passes = !c || z;
            COND_GE: passes = (n == v);      // Signed compares
            COND_LT: passes = (n != v);
            COND_GT: passes = !z && (n == v);
            COND_LE: passes = z || (n != v);
            default: passes = 1'b1;          // AL and the unused code
        endcase
    end

endmodule

//--- design/dataproc_alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data-processing ALU. Produces the result, whether Rd is written, and the
// N/Z/C/V values that an S-bit instruction would store. Combinational.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "exec_defs.svh"

module dataproc_alu
    import exec_pkg::*;
(
    input  alu_op_t op,
    input  word_t   op_rn,
    input  word_t   operand2,
    output word_t   result,
    output logic    writes_rd,
    output flags_t  new_flags
);

    localparam int MSB = `EXEC_WIDTH - 1;

    logic [`EXEC_WIDTH:0] sum;     // Carry in the top bit
    logic [`EXEC_WIDTH:0] diff;    // Top bit set on borrow
    logic                 add_ovf;
    logic                 sub_ovf;

    assign sum  = {1'b0, op_rn} + {1'b0, operand2};
    assign diff = {1'b0, op_rn} - {1'b0, operand2};

    // Signed overflow from the operand and result signs
    assign add_ovf = (op_rn[MSB] == operand2[MSB]) && (sum[MSB] != op_rn[MSB]);
    assign sub_ovf = (op_rn[MSB] != operand2[MSB]) && (diff[MSB] != op_rn[MSB]);

    always_comb begin
        writes_rd = 1'b1;
        case (op)
            OP_EOR: result = op_rn ^ operand2;
            OP_SUB: result = diff[MSB:0];
            OP_ADD: result = sum[MSB:0];
            OP_TST: begin
                result    = op_rn & operand2;
                writes_rd = 1'b0;
            end
            OP_TEQ: begin
                result    = op_rn ^ operand2;
                writes_rd = 1'b0;
            end
            OP_CMP: begin
                result    = diff[MSB:0];
                writes_rd = 1'b0;
            end
            OP_ORR: result = op_rn | operand2;
            OP_MOV: result = operand2;
            OP_BIC: result = op_rn & ~operand2;
            OP_MVN: result = ~operand2;
            default: begin                  // Unsupported opcode, no write
                result    = op_rn;
                writes_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        new_flags = '0;                     // C and V clear unless arithmetic
        new_flags[`EXEC_FLAG_N] = result[MSB];
        new_flags[`EXEC_FLAG_Z] = (result == '0);
        if (op == OP_ADD) begin
            new_flags[`EXEC_FLAG_C] = sum[`EXEC_WIDTH];
            new_flags[`EXEC_FLAG_V] = add_ovf;
        end else if (op == OP_SUB || op == OP_CMP) begin
            new_flags[`EXEC_FLAG_C] = !diff[`EXEC_WIDTH];   // Rn >= operand2
            new_flags[`EXEC_FLAG_V] = sub_ovf;
        end
    end

endmodule

//--- design/exec_defs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, register numbers, flag positions and instruction field positions
// for the execute stage. Include it in any file that needs these values;
// the guard makes repeated includes harmless.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_WIDTH 32         // Data word
`define EXEC_REG_ADDR_W 4     // Sixteen registers
`define EXEC_PC_INDEX 15      // R15 is the PC
`define EXEC_LINK_OFFSET 4    // pc runs two instructions ahead

// CPSR subset, N/Z/C/V
`define EXEC_FLAG_COUNT 4
`define EXEC_FLAG_N 3
`define EXEC_FLAG_Z 2
`define EXEC_FLAG_C 1
`define EXEC_FLAG_V 0

// Fields common to all formats
`define EXEC_COND_MSB 31
`define EXEC_COND_LSB 28
`define EXEC_FMT_MSB 27
`define EXEC_FMT_LSB 26

// Data-processing fields
`define EXEC_IMM_BIT 25
`define EXEC_OPCODE_MSB 24
`define EXEC_OPCODE_LSB 21
`define EXEC_SET_FLAGS_BIT 20
`define EXEC_RN_MSB 19
`define EXEC_RN_LSB 16
`define EXEC_RD_MSB 15
`define EXEC_RD_LSB 12
`define EXEC_OPND2_MSB 11
`define EXEC_RM_MSB 3
`define EXEC_RM_LSB 0

// Operand2 subfields
`define EXEC_ROT_MSB 11       // Immediate form
`define EXEC_ROT_LSB 8
`define EXEC_SHAMT_MSB 11     // Register form
`define EXEC_SHAMT_LSB 7
`define EXEC_SHTYPE_MSB 6
`define EXEC_SHTYPE_LSB 5

// Branch fields
`define EXEC_LINK_BIT 24
`define EXEC_BR_OFFSET_MSB 23

`endif

//--- design/exec_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the execute stage modules: data words, register numbers,
// flags and the encodings of format, opcode, condition and shift type.
// Modules take them by a wildcard import in their header.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "exec_defs.svh"

package exec_pkg;

    typedef logic [`EXEC_WIDTH-1:0]      word_t;
    typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EXEC_FLAG_COUNT-1:0] flags_t;
    typedef logic [4:0]                  shift_amt_t;   // Shift or rotate amount

    // Instruction bits 27:26
    typedef enum logic [1:0] {
        FMT_DATA   = 2'b00,
        FMT_MEMORY = 2'b01,
        FMT_BRANCH = 2'b10
    } inst_fmt_t;

    // ARM opcode values, supported subset only
    typedef enum logic [3:0] {
        OP_EOR = 4'h1,
        OP_SUB = 4'h2,
        OP_ADD = 4'h4,
        OP_TST = 4'h8,
        OP_TEQ = 4'h9,
        OP_CMP = 4'hA,
        OP_ORR = 4'hC,
        OP_MOV = 4'hD,
        OP_BIC = 4'hE,
        OP_MVN = 4'hF
    } alu_op_t;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL
    } cond_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'b00,
        SHIFT_LSR = 2'b01,
        SHIFT_ASR = 2'b10,
        SHIFT_ROR = 2'b11
    } shift_type_t;

endpackage

//--- design/exec_result.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result register of the execute stage. Captures one instruction per
// enabled cycle, keeps the flags and the one-entry forwarding record, and
// resolves branch targets and link values. Everything holds while enable
// is low.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_result
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      nreset,
    input  logic      enable,
    input  word_t     inst,
    input  inst_fmt_t fmt,
    input  logic      passes,
    input  reg_addr_t rd_addr,
    input  logic      set_flags,
    input  logic      writes_rd,
    input  word_t     result,
    input  flags_t    new_flags,
    input  word_t     pc,
    input  word_t     branch_offset,
    input  logic      link,
    output logic      ready,
    output flags_t    flags,
    output word_t     result_inst,
    output logic      update_rd,
    output word_t     rd_value,
    output logic      update_pc,
    output word_t     new_pc,
    output logic      flush_for_pc,
    output logic      fwd_valid,
    output reg_addr_t fwd_addr,
    output word_t     fwd_value
);

    logic exec_data;
    logic exec_branch;
    logic rd_is_pc;

    // Memory format and failed conditions fall through as no-ops
    assign exec_data   = passes && (fmt == FMT_DATA);
    assign exec_branch = passes && (fmt == FMT_BRANCH);
    assign rd_is_pc    = (rd_addr == reg_addr_t'(`EXEC_PC_INDEX));

    always_ff @(posedge clk) begin
        if (nreset) begin
            ready        <= 1'b0;
            flags        <= '0;
            result_inst  <= '0;
            update_rd    <= 1'b0;
            update_pc    <= 1'b0;
            flush_for_pc <= 1'b0;
            fwd_valid    <= 1'b0;
        end else begin
            ready <= enable;
            if (enable) begin
                result_inst  <= inst;
                update_rd    <= (exec_data && writes_rd) || (exec_branch && link);
                update_pc    <= exec_branch;
                flush_for_pc <= exec_branch || (exec_data && rd_is_pc);
                fwd_valid    <= exec_data && writes_rd && !rd_is_pc;  // Nothing past a flush
                if (exec_data && set_flags) begin
                    flags <= new_flags;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            if (exec_data) begin
                rd_value <= result;
                fwd_addr <= rd_addr;
            end else if (exec_branch && link) begin
                rd_value <= pc - word_t'(`EXEC_LINK_OFFSET);  // Return address
            end
            if (exec_branch) begin
                new_pc <= pc + branch_offset;
            end
        end
    end

    // The record's value is the last data result, already held in rd_value
    assign fwd_value = rd_value;

endmodule

//--- design/executor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage top. Takes one instruction with its operands and pc per
// enabled cycle and presents the registered write-back and branch outputs
// one cycle later. condition_passes reflects the instruction at the input.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module executor
    import exec_pkg::*;
(
    input  logic   clk,
    input  logic   nreset,
    input  logic   enable,
    input  word_t  inst,
    input  word_t  rn_value,      // From the register file
    input  word_t  rm_value,
    input  word_t  pc,            // Fetch address plus 8
    output logic   ready,
    output flags_t cpsr,
    output logic   condition_passes,
    output word_t  result_inst,
    output logic   update_rd,
    output word_t  rd_value,
    output logic   update_pc,
    output word_t  new_pc,
    output logic   flush_for_pc
);

    // Decoded fields
    inst_fmt_t   fmt;
    cond_t       cond;
    alu_op_t     op;
    logic        set_flags;
    reg_addr_t   rd_addr;
    word_t       op_rn;
    word_t       op_rm;
    logic        imm_operand;
    logic [11:0] shift_field;
    word_t       branch_offset;
    logic        link;

    // Execute results
    word_t  operand2;
    word_t  result;
    logic   writes_rd;
    flags_t new_flags;

    // Forwarding record from the result stage
    logic      fwd_valid;
    reg_addr_t fwd_addr;
    word_t     fwd_value;

    inst_decode u_decode (
        .inst, .rn_value, .rm_value, .fwd_valid, .fwd_addr, .fwd_value,
        .fmt, .cond, .op, .set_flags, .rd_addr, .op_rn, .op_rm,
        .imm_operand, .shift_field, .branch_offset, .link
    );

    cond_check u_cond (
        .flags  (cpsr),
        .cond,
        .passes (condition_passes)
    );

    operand_shifter u_shifter (
        .imm_operand, .shift_field, .op_rm, .operand2
    );

    dataproc_alu u_alu (
        .op, .op_rn, .operand2, .result, .writes_rd, .new_flags
    );

    exec_result u_result (
        .clk, .nreset, .enable, .inst, .fmt,
        .passes (condition_passes),
        .rd_addr, .set_flags, .writes_rd, .result, .new_flags,
        .pc, .branch_offset, .link, .ready,
        .flags  (cpsr),
        .result_inst, .update_rd, .rd_value, .update_pc, .new_pc,
        .flush_for_pc, .fwd_valid, .fwd_addr, .fwd_value
    );

endmodule

//--- design/inst_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Splits an instruction into its fields and picks the operand values,
// taking the previous result in place of the register file value when the
// addresses match. Purely combinational.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "exec_defs.svh"

module inst_decode
    import exec_pkg::*;
(
    input  word_t       inst,
    input  word_t       rn_value,
    input  word_t       rm_value,
    input  logic        fwd_valid,
    input  reg_addr_t   fwd_addr,
    input  word_t       fwd_value,
    output inst_fmt_t   fmt,
    output cond_t       cond,
    output alu_op_t     op,
    output logic        set_flags,
    output reg_addr_t   rd_addr,
    output word_t       op_rn,
    output word_t       op_rm,
    output logic        imm_operand,
    output logic [11:0] shift_field,
    output word_t       branch_offset,
    output logic        link
);

    reg_addr_t rn_addr;
    reg_addr_t rm_addr;
    logic      use_fwd_rn;
    logic      use_fwd_rm;

    assign fmt         = inst_fmt_t'(inst[`EXEC_FMT_MSB:`EXEC_FMT_LSB]);
    assign cond        = cond_t'(inst[`EXEC_COND_MSB:`EXEC_COND_LSB]);
    assign op          = alu_op_t'(inst[`EXEC_OPCODE_MSB:`EXEC_OPCODE_LSB]);
    assign set_flags   = inst[`EXEC_SET_FLAGS_BIT];
    assign imm_operand = inst[`EXEC_IMM_BIT];
    assign rn_addr     = inst[`EXEC_RN_MSB:`EXEC_RN_LSB];
    assign rd_addr     = inst[`EXEC_RD_MSB:`EXEC_RD_LSB];
    assign rm_addr     = inst[`EXEC_RM_MSB:`EXEC_RM_LSB];
    assign shift_field = inst[`EXEC_OPND2_MSB:0];
    assign link        = inst[`EXEC_LINK_BIT];

    // Word offset, sign extended and scaled to bytes
    assign branch_offset = {{(`EXEC_WIDTH-26){inst[`EXEC_BR_OFFSET_MSB]}},
                            inst[`EXEC_BR_OFFSET_MSB:0], 2'b00};

    // Rm is only an operand in the register form
    assign use_fwd_rn = fwd_valid && (rn_addr == fwd_addr);
    assign use_fwd_rm = fwd_valid && !imm_operand && (rm_addr == fwd_addr);

    assign op_rn = use_fwd_rn ? fwd_value : rn_value;
    assign op_rm = use_fwd_rm ? fwd_value : rm_value;

endmodule

//--- design/operand_shifter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Builds the second ALU operand of a data-processing instruction, either
// a rotated 8-bit immediate or Rm shifted by an immediate amount.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "exec_defs.svh"

module operand_shifter
    import exec_pkg::*;
(
    input  logic        imm_operand,
    input  logic [11:0] shift_field,
    input  word_t       op_rm,
    output word_t       operand2
);

    // Rotate right through a doubled copy of the word
    function automatic word_t ror_word(input word_t value, input shift_amt_t amt);
        logic [2*`EXEC_WIDTH-1:0] doubled;
        doubled = {value, value} >> amt;
        return doubled[`EXEC_WIDTH-1:0];
    endfunction

    shift_amt_t  rot_amt;
    shift_amt_t  shift_amt;
    shift_type_t shift_type;
    word_t       imm_word;

    assign rot_amt    = {shift_field[`EXEC_ROT_MSB:`EXEC_ROT_LSB], 1'b0};   // Twice the field
    assign shift_amt  = shift_field[`EXEC_SHAMT_MSB:`EXEC_SHAMT_LSB];
    assign shift_type = shift_type_t'(shift_field[`EXEC_SHTYPE_MSB:`EXEC_SHTYPE_LSB]);
    assign imm_word   = {{(`EXEC_WIDTH-8){1'b0}}, shift_field[7:0]};

    always_comb begin
        if (imm_operand) begin
            operand2 = ror_word(imm_word, rot_amt);
        end else begin
            case (shift_type)
                SHIFT_LSL: operand2 = op_rm << shift_amt;
                SHIFT_LSR: operand2 = op_rm >> shift_amt;
                SHIFT_ASR: operand2 = word_t'($signed(op_rm) >>> shift_amt);
                default:   operand2 = ror_word(op_rm, shift_amt);
            endcase
        end
    end

endmodule

//--- files.f
+incdir+design
design/exec_pkg.sv
design/inst_decode.sv
design/cond_check.sv
design/operand_shifter.sv
design/dataproc_alu.sv
design/exec_result.sv
design/executor.sv
verification/tb_clock.sv
verification/executor_tb.sv

//--- verification/executor_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execute stage. Applies a table of instructions, one per
// clock, driven on the falling edge and checked one cycle later, followed
// by random ADDS/SUBS pairs checked against a small arithmetic model.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module executor_tb
    import exec_pkg::*;
();

    localparam int    N_RANDOM = 16;
    localparam word_t PC_BASE  = 32'h0000_1000;

    typedef struct packed {
        word_t  inst;
        word_t  rn;
        word_t  rm;
        word_t  pc;
        logic   en;
        logic   pass;       // condition_passes before the edge
        logic   upd_rd;
        word_t  rd_val;
        logic   upd_pc;
        word_t  new_pc;
        logic   flush;
        flags_t cpsr;
    } test_entry_t;

    logic   clk;
    logic   nreset;
    logic   enable;
    word_t  inst;
    word_t  rn_value;
    word_t  rm_value;
    word_t  pc;
    logic   ready;
    flags_t cpsr;
    logic   condition_passes;
    word_t  result_inst;
    logic   update_rd;
    word_t  rd_value;
    logic   update_pc;
    word_t  new_pc;
    logic   flush_for_pc;

    test_entry_t tests[$];
    string       names[$];
    logic        tests_built = 1'b0;
    int          errors = 0;
    int          failed_tests = 0;
    int          seed = 32'h47f6;

    tb_clock u_clock (.clk, .nreset);

    executor dut (
        .clk, .nreset, .enable, .inst, .rn_value, .rm_value, .pc,
        .ready, .cpsr, .condition_passes, .result_inst, .update_rd, .rd_value,
        .update_pc, .new_pc, .flush_for_pc
    );

    // Instruction encoders
    function automatic word_t dp_imm(input cond_t c, input alu_op_t op, input logic s,
                                     input reg_addr_t rn, input reg_addr_t rd,
                                     input logic [3:0] rot, input logic [7:0] imm8);
        return {c, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
    endfunction

    function automatic word_t dp_reg(input cond_t c, input alu_op_t op, input logic s,
                                     input reg_addr_t rn, input reg_addr_t rd,
                                     input shift_amt_t amt, input shift_type_t sh,
                                     input reg_addr_t rm);
        return {c, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    function automatic word_t br(input cond_t c, input logic l, input logic [23:0] off);
        return {c, 3'b101, l, off};
    endfunction

    // Result and N/Z/C/V of ADD or SUB computed from the exact signed sum
    function automatic logic [35:0] arith_model(input logic sub, input word_t a, input word_t b);
        logic signed [32:0] wide;
        word_t              res;
        logic               c;
        if (sub) begin
            wide = $signed({a[31], a}) - $signed({b[31], b});
            c    = (a >= b);
        end else begin
            wide = $signed({a[31], a}) + $signed({b[31], b});
            c    = (a > ~b);                // a + b exceeds 32 bits
        end
        res = wide[31:0];
        return {res, res[31], res == 32'd0, c, wide[32] != wide[31]};
    endfunction

    function automatic void add_test(input string name, input word_t code, input word_t rn_v,
                                     input word_t rm_v, input word_t pc_v, input logic en,
                                     input logic pass, input logic upd_rd, input word_t rd_v,
                                     input logic upd_pc, input word_t pc_exp,
                                     input logic flush, input flags_t flags);
        test_entry_t e;
        e = '{code, rn_v, rm_v, pc_v, en, pass, upd_rd, rd_v, upd_pc, pc_exp, flush, flags};
        tests.push_back(e);
        names.push_back(name);
    endfunction

    task automatic build_tests();
        word_t       a;
        word_t       b;
        logic [35:0] m;
        add_test("mov_imm_rot", dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd1, 4'd4, 8'hFF),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'hFF00_0000, 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("add_imm", dp_imm(COND_AL, OP_ADD, 1'b0, 4'd3, 4'd2, 4'd0, 8'h05),
                 32'd10, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd15, 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("sub_lsl", dp_reg(COND_AL, OP_SUB, 1'b0, 4'd5, 4'd4, 5'd2, SHIFT_LSL, 4'd6),
                 32'd100, 32'd3, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd88, 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("eor_lsr", dp_reg(COND_AL, OP_EOR, 1'b0, 4'd8, 4'd7, 5'd4, SHIFT_LSR, 4'd9),
                 32'hF0F0_F0F0, 32'hFFFF_0000, PC_BASE, 1'b1, 1'b1, 1'b1, 32'hFF0F_00F0,
                 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("orr_asr", dp_reg(COND_AL, OP_ORR, 1'b0, 4'd11, 4'd10, 5'd8, SHIFT_ASR, 4'd12),
                 32'h0000_000F, 32'h8000_0000, PC_BASE, 1'b1, 1'b1, 1'b1, 32'hFF80_000F,
                 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("bic_ror", dp_reg(COND_AL, OP_BIC, 1'b0, 4'd14, 4'd13, 5'd8, SHIFT_ROR, 4'd0),
                 32'hFFFF_FFFF, 32'h0000_00FF, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h00FF_FFFF,
                 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("mvn_imm", dp_imm(COND_AL, OP_MVN, 1'b0, 4'd0, 4'd1, 4'd0, 8'h00),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'hFFFF_FFFF, 1'b0, 32'h0, 1'b0, 4'b0000);
        add_test("tst_zero", dp_imm(COND_AL, OP_TST, 1'b1, 4'd2, 4'd0, 4'd0, 8'hF0),
                 32'h0F, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0100);
        add_test("teq_neg", dp_reg(COND_AL, OP_TEQ, 1'b1, 4'd3, 4'd0, 5'd0, SHIFT_LSL, 4'd4),
                 32'h8000_0000, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b1000);
        add_test("cmp_equal", dp_imm(COND_AL, OP_CMP, 1'b1, 4'd5, 4'd0, 4'd0, 8'h01),
                 32'd1, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0110);
        add_test("adds_carry", dp_reg(COND_AL, OP_ADD, 1'b1, 4'd7, 4'd9, 5'd0, SHIFT_LSL, 4'd8),
                 32'hFFFF_FFFF, 32'd1, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0110);
        add_test("adds_ovf", dp_reg(COND_AL, OP_ADD, 1'b1, 4'd7, 4'd9, 5'd0, SHIFT_LSL, 4'd8),
                 32'h7FFF_FFFF, 32'd1, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h8000_0000,
                 1'b0, 32'h0, 1'b0, 4'b1001);
        add_test("subs_ovf", dp_imm(COND_AL, OP_SUB, 1'b1, 4'd11, 4'd10, 4'd0, 8'h01),
                 32'h8000_0000, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h7FFF_FFFF,
                 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("moveq_skip", dp_imm(COND_EQ, OP_MOV, 1'b0, 4'd0, 4'd12, 4'd0, 8'h07),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("addhi_run", dp_imm(COND_HI, OP_ADD, 1'b0, 4'd0, 4'd12, 4'd0, 8'h01),
                 32'd41, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd42, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("fwd_rn", dp_imm(COND_AL, OP_ADD, 1'b0, 4'd12, 4'd1, 4'd0, 8'h08),
                 32'hDEAD, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd50, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("fwd_rm", dp_reg(COND_AL, OP_SUB, 1'b0, 4'd0, 4'd2, 5'd0, SHIFT_LSL, 4'd1),
                 32'd100, 32'hBAD, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd50, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("write_pc", dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd15, 4'd0, 8'h40),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h40, 1'b0, 32'h0, 1'b1, 4'b0011);
        add_test("no_fwd_pc", dp_imm(COND_AL, OP_ADD, 1'b0, 4'd15, 4'd3, 4'd0, 8'h00),
                 32'h2000, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h2000, 1'b0, 32'h0, 1'b0, 4'b0011);
        // Disabled cycle where the outputs keep the previous instruction's values
        add_test("hold", dp_imm(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd4, 4'd0, 8'h01),
                 32'h0, 32'h0, PC_BASE, 1'b0, 1'b1, 1'b1, 32'h2000, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("fwd_after_hold", dp_imm(COND_AL, OP_ADD, 1'b0, 4'd3, 4'd5, 4'd0, 8'h01),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'h2001, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("branch", br(COND_AL, 1'b0, 24'h00_0010),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b0, 32'h0, 1'b1, 32'h1040, 1'b1, 4'b0011);
        add_test("branch_link", br(COND_AL, 1'b1, 24'hFF_FFFE),
                 32'h0, 32'h0, 32'h2000, 1'b1, 1'b1, 1'b1, 32'h1FFC, 1'b1, 32'h1FF8, 1'b1, 4'b0011);
        add_test("bge_skip", br(COND_GE, 1'b0, 24'h00_0020),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("movlt_run", dp_imm(COND_LT, OP_MOV, 1'b0, 4'd0, 4'd6, 4'd0, 8'h03),
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b1, 32'd3, 1'b0, 32'h0, 1'b0, 4'b0011);
        add_test("memory_nop", 32'hE590_1000,
                 32'h0, 32'h0, PC_BASE, 1'b1, 1'b1, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 4'b0011);
        for (int k = 0; k < N_RANDOM; k++) begin
            a = $random(seed);
            b = $random(seed);
            m = arith_model(k[0], a, b);    // Odd entries subtract
            if (k[0]) begin
                add_test($sformatf("rand_subs_%0d", k),
                         dp_reg(COND_AL, OP_SUB, 1'b1, 4'd11, 4'd10, 5'd0, SHIFT_LSL, 4'd12),
                         a, b, PC_BASE, 1'b1, 1'b1, 1'b1, m[35:4], 1'b0, 32'h0, 1'b0, m[3:0]);
            end else begin
                add_test($sformatf("rand_adds_%0d", k),
                         dp_reg(COND_AL, OP_ADD, 1'b1, 4'd7, 4'd9, 5'd0, SHIFT_LSL, 4'd8),
                         a, b, PC_BASE, 1'b1, 1'b1, 1'b1, m[35:4], 1'b0, 32'h0, 1'b0, m[3:0]);
            end
        end
    endtask

    task automatic check_word(input string tname, input string what,
                              input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERR %s %s: expected %h, actual %h", tname, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string tname, input int start_errs);
        if (errors == start_errs) begin
            $display("%s: ok", tname);
        end else begin
            $display("%s: mismatch", tname);
            failed_tests++;
        end
    endtask

    task automatic check_outputs(input int i, input word_t exp_inst);
        check_word(names[i], "ready", word_t'(tests[i].en), word_t'(ready));
        check_word(names[i], "result_inst", exp_inst, result_inst);
        check_word(names[i], "update_rd", word_t'(tests[i].upd_rd), word_t'(update_rd));
        if (tests[i].upd_rd) begin
            check_word(names[i], "rd_value", tests[i].rd_val, rd_value);
        end
        check_word(names[i], "update_pc", word_t'(tests[i].upd_pc), word_t'(update_pc));
        if (tests[i].upd_pc) begin
            check_word(names[i], "new_pc", tests[i].new_pc, new_pc);
        end
        check_word(names[i], "flush_for_pc", word_t'(tests[i].flush), word_t'(flush_for_pc));
        check_word(names[i], "cpsr", word_t'(tests[i].cpsr), word_t'(cpsr));
    endtask

    initial begin
        int    start_errs;
        word_t last_inst;
        enable   = 1'b0;
        inst     = '0;
        rn_value = '0;
        rm_value = '0;
        pc       = '0;
        build_tests();
        tests_built = 1'b1;
        @(negedge nreset);
        start_errs = errors;
        check_word("reset", "ready", 32'd0, word_t'(ready));
        check_word("reset", "update_rd", 32'd0, word_t'(update_rd));
        check_word("reset", "update_pc", 32'd0, word_t'(update_pc));
        check_word("reset", "flush_for_pc", 32'd0, word_t'(flush_for_pc));
        check_word("reset", "cpsr", 32'd0, word_t'(cpsr));
        check_word("reset", "result_inst", 32'd0, result_inst);
        report_test("reset", start_errs);
        last_inst = '0;
        for (int i = 0; i < tests.size(); i++) begin
            start_errs = errors;
            enable     = tests[i].en;
            inst       = tests[i].inst;
            rn_value   = tests[i].rn;
            rm_value   = tests[i].rm;
            pc         = tests[i].pc;
            #10;                                // Let the decode settle
            check_word(names[i], "condition_passes", word_t'(tests[i].pass),
                       word_t'(condition_passes));
            @(negedge clk);
            if (tests[i].en) begin
                last_inst = tests[i].inst;
            end
            check_outputs(i, last_inst);
            report_test(names[i], start_errs);
        end
        $display("%0d tests, %0d mismatched, %0d check errors",
                 tests.size() + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // One clock per test plus reset and some slack
    initial begin : watchdog
        int limit_ns;
        wait (tests_built);
        limit_ns = (tests.size() + 4) * 100 + 1000;
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source. Runs a 100 ns clock and holds the
// synchronous reset for the first two rising edges.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic nreset
);

    localparam int PERIOD = 100;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        nreset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nreset = 1'b0;                    // Released between edges
    end

endmodule
